//--- Makefile
TOP = cpuTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

//--- filelist.f
+incdir+include
hw/cpuPkg.sv
hw/alu.sv
hw/registerFile.sv
hw/control.sv
hw/datapath.sv
hw/cpuCore.sv
verification/busProtocol_checker.sv
verification/cpuTb.sv

//--- hw/alu.sv
// Combinational ALU of the core, giving the result and the new Z, N, V and C flags
module alu(
   input  cpuPkg::aluFunction_t Function,
   input  logic [15:0]          A,
   input  logic [15:0]          B,
   input  logic                 CarryIn,
   output logic [15:0]          Result,
   output logic [3:0]           Flags
);
   import cpuPkg::*;

   localparam int Msb = WordWidth - 1;

   logic [WordWidth:0] Sum;      // Top bit is carry out
   logic [WordWidth:0] CarryExt;
   logic [3:0]         Count;
   logic               Overflow;
   logic               Arith;

   assign CarryExt = {{WordWidth{1'b0}}, CarryIn};
   assign Count = B[3:0];
   assign Arith = Function inside {FnADD, FnADC, FnSUB, FnNEG};

   always_comb begin
      Sum = '0;
      Overflow = 1'b0;
      case (Function)
         FnADD, FnADC: begin
            Sum = {1'b0, A} + {1'b0, B};
            if (Function == FnADC)
               Sum = Sum + CarryExt;
            Overflow = (A[Msb] == B[Msb]) && (Sum[Msb] != A[Msb]);
         end
         FnSUB: begin
            Sum = {1'b0, A} + {1'b0, ~B} + CarryExt;
            Overflow = (A[Msb] != B[Msb]) && (Sum[Msb] != A[Msb]);
         end
         FnNEG: begin
            Sum = {1'b0, ~A} + (WordWidth + 1)'(1);
            Overflow = A[Msb] && Sum[Msb];  // Only for the most negative value
         end
         default: Sum = '0;
      endcase
   end

   always_comb begin
      case (Function)
         FnADD, FnADC, FnSUB, FnNEG: Result = Sum[Msb:0];
         FnAND:   Result = A & B;
         FnOR:    Result = A | B;
         FnXOR:   Result = A ^ B;
         FnNOT:   Result = ~A;
         FnNAND:  Result = ~(A & B);
         FnNOR:   Result = ~(A | B);
         FnLSL:   Result = A << Count;
         FnLSR:   Result = A >> Count;
         FnASR:   Result = $signed(A) >>> Count;
         FnLUI:   Result = {B[7:0], A[7:0]};
         FnLLI:   Result = {A[15:8], B[7:0]};
         default: Result = A;
      endcase
      Flags[FlagZ] = (Result == '0);
      Flags[FlagN] = Result[Msb];
      Flags[FlagV] = Overflow;
      Flags[FlagC] = Arith && Sum[WordWidth];  // Logic and shifts clear C
   end

endmodule

//--- hw/control.sv
// Fetch/execute sequencer of the core; owns the status register and decodes the control word
`include "flags.svh"

module control(
   input  logic               Clock,
   input  logic               nReset,
   input  logic [7:0]         OpcodeCond,
   input  logic [3:0]         NewFlags,
   input  logic               nWait,
   output cpuPkg::ctrlWord_t  Ctrl,
   output cpuPkg::busCtrl_t   Bus,
   output logic               CFlag
);
   import cpuPkg::*;

   typedef enum logic {Fetch, Execute} majorState_t;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycle_t;

   majorState_t  State;
   subCycle_t    SubCycle;
   opcode_t      Opcode;
   branch_t      BranchCode;
   aluFunction_t OpFunction;
   logic [3:0]   StatusReg;
   logic         StatusRegWe;
   logic         MemoryOp;
   logic         Taken;

   assign Opcode = opcode_t'(OpcodeCond[7:3]);
   assign BranchCode = branch_t'(OpcodeCond[2:0]);
   assign MemoryOp = (Opcode == LDW) || (Opcode == STW);

   // Carry ops take C, a plain subtract sees carry in as no borrow
   assign CFlag = (Opcode inside {ADC, ADCI, SUC, SUCI}) ? StatusReg[`FLAGS_C] : 1'b1;

   assign StatusRegWe = (State == Execute) && (SubCycle == Cycle0) &&
                        !(Opcode inside {LUI, LLI, LDW, STW, BRANCH});

   always_comb begin
      case (BranchCode)
         BNE:     Taken = !StatusReg[`FLAGS_Z];
         BE:      Taken = StatusReg[`FLAGS_Z];
         BLT:     Taken = StatusReg[`FLAGS_N] != StatusReg[`FLAGS_V];
         BGE:     Taken = StatusReg[`FLAGS_N] == StatusReg[`FLAGS_V];
         default: Taken = 1'b1;  // BR and BWL
      endcase
   end

   always_comb begin
      case (Opcode)
         ADD, ADDI, ADDIB, LDW, STW, BRANCH: OpFunction = FnADD;
         ADC, ADCI:                          OpFunction = FnADC;
         SUB, SUBI, SUBIB, SUC, SUCI:        OpFunction = FnSUB;
         CMP, CMPI:                          OpFunction = FnSUB;
         NEG:     OpFunction = FnNEG;
         AND:     OpFunction = FnAND;
         OR:      OpFunction = FnOR;
         XOR:     OpFunction = FnXOR;
         NOT:     OpFunction = FnNOT;
         NAND:    OpFunction = FnNAND;
         NOR:     OpFunction = FnNOR;
         LSL:     OpFunction = FnLSL;
         LSR:     OpFunction = FnLSR;
         ASR:     OpFunction = FnASR;
         LUI:     OpFunction = FnLUI;
         LLI:     OpFunction = FnLLI;
         default: OpFunction = FnA;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         State <= Fetch;
         SubCycle <= Cycle0;
         StatusReg <= '0;
      end else begin
         if (StatusRegWe)
            StatusReg <= NewFlags;
         if (State == Fetch) begin
            case (SubCycle)
               Cycle0: SubCycle <= Cycle1;
               Cycle1: SubCycle <= Cycle2;
               Cycle2: if (nWait)
                          SubCycle <= Cycle3;
               default: begin
                  State <= Execute;
                  SubCycle <= Cycle0;
               end
            endcase
         end else begin
            case (SubCycle)
               Cycle0: if (MemoryOp)
                          SubCycle <= Cycle1;
                       else
                          State <= Fetch;
               Cycle1: SubCycle <= Cycle2;
               Cycle2: SubCycle <= Cycle3;
               Cycle3: if (nWait)    // Memory data phase
                          SubCycle <= Cycle4;
               default: begin
                  State <= Fetch;
                  SubCycle <= Cycle0;
               end
            endcase
         end
      end
   end

   always_comb begin
      Ctrl = '0;
      Bus = '{ALE: 1'b0, nME: 1'b1, nOE: 1'b1, nWE: 1'b1, ENB: 1'b0};
      if (State == Fetch) begin
         case (SubCycle)
            Cycle0: begin
               Bus.ALE = 1'b1;
               Ctrl.PcEn = 1'b1;       // Fetch address
            end
            Cycle1, Cycle2: begin
               Bus.nME = 1'b0;
               Bus.nOE = 1'b0;
               Bus.ENB = (SubCycle == Cycle2);
               Ctrl.MemEn = 1'b1;
            end
            default: begin
               Ctrl.MemEn = 1'b1;
               Ctrl.IrWe = 1'b1;
            end
         endcase
      end else begin
         case (SubCycle)
            Cycle0: begin
               Ctrl.AluOp = OpFunction;
               Ctrl.AluWe = MemoryOp;  // Effective address for LDW/STW
               Ctrl.PcWe = !MemoryOp;
               Ctrl.RegWe = !(Opcode inside {CMP, CMPI, LDW, STW, BRANCH});
               case (Opcode)
                  ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR: Ctrl.Op2Sel = Op2Rd2;
                  ADDIB, SUBIB, LUI, LLI: begin
                     Ctrl.Rs1Sel = Rs1Rd;
                     Ctrl.Op2Sel = Op2Imm;
                     Ctrl.ImmSel = ImmLong;
                  end
                  BRANCH: begin
                     case (BranchCode)
                        RET: begin
                           Ctrl.LrEn = 1'b1;
                           Ctrl.PcSel = PcSysbus;
                        end
                        JMP: begin
                           Ctrl.Op2Sel = Op2Imm;   // Ra plus short immediate
                           Ctrl.PcSel = PcAluOut;
                        end
                        default: begin
                           Ctrl.Op1Sel = Op1Pc;
                           Ctrl.Op2Sel = Op2Imm;
                           Ctrl.ImmSel = ImmLong;
                           Ctrl.LrSel = LrPc;
                           if (Taken) begin
                              Ctrl.PcSel = PcAluOut;
                              Ctrl.LrWe = (BranchCode == BWL);
                           end
                        end
                     endcase
                  end
                  default: Ctrl.Op2Sel = Op2Imm;
               endcase
            end
            Cycle1: begin
               Bus.ALE = 1'b1;
               Ctrl.AluEn = 1'b1;
            end
            Cycle2: begin
               Bus.nME = 1'b0;
               if (Opcode == LDW) begin
                  Bus.nOE = 1'b0;
                  Ctrl.MemEn = 1'b1;
               end else begin
                  Ctrl.AluEn = 1'b1;
                  Ctrl.Rs1Sel = Rs1Rd;  // Store data through the ALU register
                  Ctrl.AluWe = 1'b1;
               end
            end
            Cycle3: begin
               Bus.nME = 1'b0;
               if (Opcode == LDW) begin
                  Bus.nOE = 1'b0;
                  Bus.ENB = 1'b1;
                  Ctrl.MemEn = 1'b1;
               end else begin
                  Bus.nWE = 1'b0;
                  Ctrl.AluEn = 1'b1;
               end
            end
            default: begin
               Ctrl.PcWe = 1'b1;
               if (Opcode == LDW) begin
                  Ctrl.MemEn = 1'b1;
                  Ctrl.WdSel = WdSys;
                  Ctrl.RegWe = 1'b1;
               end else begin
                  Ctrl.AluEn = 1'b1;
               end
            end
         endcase
      end
   end

endmodule

//--- hw/cpuCore.sv
// Top level of the core, joining the sequencer and the datapath to the multiplexed memory bus
module cpuCore(
   input  logic              Clock,
   input  logic              nReset,
   input  logic [15:0]       AddrDataIn,
   input  logic              nWait,
   output logic [15:0]       AddrDataOut,
   output logic              AddrDataOe,
   output cpuPkg::busCtrl_t  Bus
);
   import cpuPkg::*;

   ctrlWord_t  Ctrl;
   logic [7:0] OpcodeCond;
   logic [3:0] NewFlags;
   logic       CFlag;

   control sequencer(
      .Clock,
      .nReset,
      .OpcodeCond,
      .NewFlags,
      .nWait,
      .Ctrl,
      .Bus,
      .CFlag
   );

   datapath dataPath(
      .Clock,
      .nReset,
      .Ctrl,
      .Bus,
      .CFlag,
      .AddrDataIn,
      .OpcodeCond,
      .NewFlags,
      .AddrDataOut,
      .AddrDataOe
   );

endmodule

//--- hw/cpuPkg.sv
// Shared encodings and control structs of the 16-bit core, imported by the RTL modules
`include "flags.svh"

package cpuPkg;

   localparam int WordWidth = 16;
   localparam int ShortImmWidth = 5;
   localparam int LongImmWidth = 8;

   localparam int FlagZ = `FLAGS_Z;
   localparam int FlagN = `FLAGS_N;
   localparam int FlagV = `FLAGS_V;
   localparam int FlagC = `FLAGS_C;

   typedef enum logic [4:0] {
      ADD = 5'h00, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB,
      SUC = 5'h08, SUCI, NEG, CMP, CMPI, AND, OR, XOR,
      NOT = 5'h10, NAND, NOR, LSL, LSR, ASR, LUI, LLI,
      LDW = 5'h18, STW,
      BRANCH = 5'h1F
   } opcode_t;

   typedef enum logic [2:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } branch_t;

   typedef enum logic [3:0] {
      FnA, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFunction_t;

   // Zero value of each select is the common case
   typedef enum logic {Op1Rd1, Op1Pc} op1Select_t;
   typedef enum logic {Op2Rd2, Op2Imm} op2Select_t;
   typedef enum logic {ImmShort, ImmLong} immSelect_t;
   typedef enum logic {WdAlu, WdSys} wdSelect_t;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelect_t;
   typedef enum logic {LrSys, LrPc} lrSelect_t;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Select_t;

   // Instruction word, most significant field first
   typedef struct packed {
      opcode_t    Opcode;  // 15:11
      logic [2:0] Rd;      // 10:8, branch code for BRANCH
      logic [2:0] Ra;      // 7:5
      logic [2:0] Rb;      // 4:2
      logic [1:0] Spare;
   } instr_t;

   typedef struct packed {
      aluFunction_t AluOp;
      op1Select_t   Op1Sel;
      op2Select_t   Op2Sel;
      immSelect_t   ImmSel;
      wdSelect_t    WdSel;
      pcSelect_t    PcSel;
      lrSelect_t    LrSel;
      rs1Select_t   Rs1Sel;
      logic         AluEn;   // System bus drivers, one-hot
      logic         LrEn;
      logic         PcEn;
      logic         MemEn;
      logic         IrWe;
      logic         RegWe;
      logic         PcWe;
      logic         LrWe;
      logic         AluWe;
   } ctrlWord_t;

   typedef struct packed {
      logic ALE;
      logic nME;
      logic nOE;
      logic nWE;
      logic ENB;
   } busCtrl_t;

endpackage

//--- hw/datapath.sv
// Datapath of the core: IR, PC, LR, operand muxes, ALU, system bus mux and memory pad interface
module datapath(
   input  logic               Clock,
   input  logic               nReset,
   input  cpuPkg::ctrlWord_t  Ctrl,
   input  cpuPkg::busCtrl_t   Bus,
   input  logic               CFlag,
   input  logic [15:0]        AddrDataIn,
   output logic [7:0]         OpcodeCond,
   output logic [3:0]         NewFlags,
   output logic [15:0]        AddrDataOut,
   output logic               AddrDataOe
);
   import cpuPkg::*;

   instr_t               Ir;
   logic [WordWidth-1:0] Pc;
   logic [WordWidth-1:0] PcPlus1;
   logic [WordWidth-1:0] Lr;
   logic [WordWidth-1:0] AluReg;
   logic [WordWidth-1:0] MemLatch;
   logic [WordWidth-1:0] SysBus;
   logic [WordWidth-1:0] ShortImm;
   logic [WordWidth-1:0] LongImm;
   logic [WordWidth-1:0] ReadData1;
   logic [WordWidth-1:0] ReadData2;
   logic [WordWidth-1:0] Op1;
   logic [WordWidth-1:0] Op2;
   logic [WordWidth-1:0] AluResult;
   logic [WordWidth-1:0] WriteData;
   logic [2:0]           ReadAddr1;

   assign OpcodeCond = {Ir.Opcode, Ir.Rd};
   assign PcPlus1 = Pc + 1'b1;

   assign ShortImm = {{(WordWidth - ShortImmWidth){Ir[ShortImmWidth-1]}},
                      Ir[ShortImmWidth-1:0]};
   assign LongImm = {{(WordWidth - LongImmWidth){Ir[LongImmWidth-1]}}, Ir[LongImmWidth-1:0]};

   assign ReadAddr1 = (Ctrl.Rs1Sel == Rs1Rd) ? Ir.Rd : Ir.Ra;
   assign Op1 = (Ctrl.Op1Sel == Op1Pc) ? Pc : ReadData1;
   assign Op2 = (Ctrl.Op2Sel == Op2Rd2) ? ReadData2 : (Ctrl.ImmSel == ImmLong) ? LongImm : ShortImm;
   assign WriteData = (Ctrl.WdSel == WdSys) ? SysBus : AluResult;

   // System bus, the enables are one-hot
   always_comb begin
      case (1'b1)
         Ctrl.PcEn:  SysBus = Pc;
         Ctrl.AluEn: SysBus = AluReg;
         Ctrl.LrEn:  SysBus = Lr;
         Ctrl.MemEn: SysBus = MemLatch;
         default:    SysBus = '0;
      endcase
   end

   assign AddrDataOut = SysBus;
   assign AddrDataOe = Bus.nOE || Bus.ALE;  // Pads released while memory drives

   registerFile regs(
      .Clock,
      .nReset,
      .ReadAddr1,
      .ReadAddr2(Ir.Rb),
      .WriteAddr(Ir.Rd),
      .WriteData,
      .WriteEnable(Ctrl.RegWe),
      .ReadData1,
      .ReadData2
   );

   alu alu0(
      .Function(Ctrl.AluOp),
      .A(Op1),
      .B(Op2),
      .CarryIn(CFlag),
      .Result(AluResult),
      .Flags(NewFlags)
   );

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Pc <= '0;
         Ir <= '0;
      end else begin
         if (Ctrl.PcWe) begin
            case (Ctrl.PcSel)
               Pc1:      Pc <= PcPlus1;
               PcAluOut: Pc <= AluResult;
               default:  Pc <= SysBus;
            endcase
         end
         if (Ctrl.IrWe)
            Ir <= instr_t'(SysBus);
      end
   end

   always_ff @(posedge Clock) begin
      if (Ctrl.LrWe)
         Lr <= (Ctrl.LrSel == LrPc) ? PcPlus1 : SysBus;
      if (Ctrl.AluWe)
         AluReg <= AluResult;
      if (Bus.ENB)
         MemLatch <= AddrDataIn;  // Read data from the pads
   end

endmodule

//--- hw/registerFile.sv
// Eight 16-bit registers with two asynchronous read ports and one synchronous write port
module registerFile(
   input  logic        Clock,
   input  logic        nReset,
   input  logic [2:0]  ReadAddr1,
   input  logic [2:0]  ReadAddr2,
   input  logic [2:0]  WriteAddr,
   input  logic [15:0] WriteData,
   input  logic        WriteEnable,
   output logic [15:0] ReadData1,
   output logic [15:0] ReadData2
);

   logic [15:0] Regs [8];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < 8; i++)
            Regs[i] <= '0;
      end else if (WriteEnable) begin
         Regs[WriteAddr] <= WriteData;  // R0 is an ordinary register
      end
   end

   assign ReadData1 = Regs[ReadAddr1];
   assign ReadData2 = Regs[ReadAddr2];

endmodule

//--- include/flags.svh
// Bit positions of the Z, N, V and C flags in the four-bit status word, pulled in by `include
`ifndef FLAGS_SVH
`define FLAGS_SVH

`define FLAGS_Z 0
`define FLAGS_N 1
`define FLAGS_V 2
`define FLAGS_C 3

`endif

//--- verification/busProtocol_checker.sv
// Concurrent bus timing assertions for cpuCore, attached to every core instance by bind
module busProtocol_checker(
   input logic             Clock,
   input logic             nReset,
   input logic             nWait,
   input cpuPkg::busCtrl_t Bus,
   input logic [15:0]      AddrDataOut,
   input logic             AddrDataOe
);
   timeunit 1ns;
   timeprecision 100ps;

   int   Violations = 0;
   logic DataPhase;

   // Read data latch or write strobe active with the chip selected
   assign DataPhase = !Bus.nME && (Bus.ENB || !Bus.nWE);

   addressThenSelect: assert property (@(posedge Clock) disable iff (!nReset)
      Bus.ALE |-> ##[1:2] !Bus.nME)
      else begin
         Violations++;
         $error("ALE was not followed by chip select within two cycles");
      end

   noReadWriteOverlap: assert property (@(posedge Clock) disable iff (!nReset)
      Bus.nWE || Bus.nOE)
      else begin
         Violations++;
         $error("nOE and nWE low together");
      end

   coreDrivesPads: assert property (@(posedge Clock) disable iff (!nReset)
      (Bus.ALE || !Bus.nWE) |-> AddrDataOe)
      else begin
         Violations++;
         $error("Core did not drive the pads for an address or write data");
      end

   stallHoldsBus: assert property (@(posedge Clock) disable iff (!nReset)
      (DataPhase && !nWait) |=> $stable(Bus))
      else begin
         Violations++;
         $error("Bus strobes changed while nWait was low");
      end

   phaseCompletes: assert property (@(posedge Clock) disable iff (!nReset)
      (DataPhase && nWait) |=> Bus.nME)
      else begin
         Violations++;
         $error("Data phase did not end after nWait went high");
      end

   firstFetchAtZero: assert property (@(posedge Clock)
      $rose(nReset) |-> (Bus.ALE && AddrDataOut == 16'h0000))
      else begin
         Violations++;
         $error("First bus cycle after reset did not fetch address zero");
      end

endmodule

bind cpuCore busProtocol_checker busCheck(
   .Clock,
   .nReset,
   .nWait,
   .Bus,
   .AddrDataOut,
   .AddrDataOe
);

//--- verification/cpuTb.sv
// Testbench for cpuCore that runs a preloaded program on a wait-state memory and checks the results
module cpuTb;
   timeunit 1ns;
   timeprecision 100ps;
   import cpuPkg::*;

   localparam logic [15:0] OpA = 16'h1234;
   localparam logic [15:0] OpB = 16'h0FF0;
   localparam int ResultBase = 8'h80;
   localparam int Slots = 20;

   logic        Clock;
   logic        nReset;
   logic        nWait;
   logic [15:0] AddrDataIn;
   logic [15:0] AddrDataOut;
   logic        AddrDataOe;
   busCtrl_t    Bus;

   logic [15:0] mem [256];
   logic [7:0]  memAddr;
   logic [15:0] expected [Slots];
   logic [15:0] negA;
   int          loadPc;
   int          baseSlot;
   int          finalPc;
   int          waitLeft;
   int          cycles;

   cpuCore u_dut(
      .Clock,
      .nReset,
      .AddrDataIn,
      .nWait,
      .AddrDataOut,
      .AddrDataOe,
      .Bus
   );

   function automatic logic [15:0] regOp(opcode_t op, int rd, int ra, int rb);
      return {op, 3'(rd), 3'(ra), 3'(rb), 2'b00};
   endfunction

   function automatic logic [15:0] immOp(opcode_t op, int rd, int ra, int imm);
      return {op, 3'(rd), 3'(ra), 5'(imm)};
   endfunction

   function automatic logic [15:0] byteOp(opcode_t op, int rd, int imm);
      return {op, 3'(rd), 8'(imm)};
   endfunction

   function automatic logic [15:0] branchOp(branch_t code, int offset);
      return {BRANCH, code, 8'(offset)};
   endfunction

   function automatic logic [15:0] marker(int slot, bit taken);
      return taken ? 16'(16'h00B0 + slot) : 16'(16'h00A0 + slot);
   endfunction

   task automatic emit(logic [15:0] word);
      mem[loadPc] <= word;
      loadPc++;
   endtask

   task automatic emitStore(int rd, int slot);
      emit(immOp(STW, rd, 7, slot - baseSlot));
   endtask

   // Branch over a not-taken marker to a taken marker, then store R3
   task automatic emitBranch(branch_t code, int slot, bit taken);
      emit(branchOp(code, 3));
      emit(byteOp(LLI, 3, marker(slot, 1'b0)));
      emit(branchOp(BR, 2));
      emit(byteOp(LLI, 3, marker(slot, 1'b1)));
      emitStore(3, slot);
      expected[slot] = marker(slot, taken);
   endtask

   task automatic stopWithFailure(string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic loadProgram();
      for (int i = 0; i < 256; i++)
         mem[i] <= 16'hD000 ^ {i[7:0], i[7:0]};  // Fill pattern
      mem[8'hF0] <= 16'hBEEF;
      loadPc = 0;
      baseSlot = 0;
      emit(byteOp(LLI, 7, ResultBase));
      emit(byteOp(LUI, 1, OpA[15:8]));
      emit(byteOp(LLI, 1, OpA[7:0]));
      emitStore(1, 0);
      emit(byteOp(LLI, 2, OpB[7:0]));
      emit(byteOp(LUI, 2, OpB[15:8]));
      emit(regOp(ADD, 3, 1, 2));
      emitStore(3, 1);
      emit(regOp(SUB, 3, 1, 2));
      emitStore(3, 2);
      emit(byteOp(LUI, 4, 8'hFF));
      emit(byteOp(LLI, 4, 8'hFF));
      emit(regOp(ADD, 5, 4, 1));   // Sets C for the ADC below
      emitStore(5, 3);
      emit(regOp(ADC, 6, 1, 2));
      emitStore(6, 4);
      emit(regOp(AND, 3, 1, 2));
      emitStore(3, 5);
      emit(regOp(OR, 3, 1, 2));
      emitStore(3, 6);
      emit(regOp(XOR, 3, 1, 2));
      emitStore(3, 7);
      emit(regOp(NOR, 3, 1, 2));
      emitStore(3, 8);
      emit(immOp(LSL, 3, 1, 4));
      emitStore(3, 9);
      emit(regOp(NEG, 3, 1, 0));
      emit(immOp(ASR, 3, 3, 4));
      emitStore(3, 10);
      emit(immOp(LSR, 3, 3, 4));
      emitStore(3, 11);
      emit(byteOp(LUI, 6, 8'h00));
      emit(byteOp(LLI, 6, 8'hF0));
      emit(immOp(LDW, 5, 6, 0));   // Copy of the preloaded word
      emitStore(5, 12);
      emit(immOp(ADDI, 7, 7, 10));
      baseSlot = 10;
      emit(regOp(AND, 3, 0, 0));
      emit(regOp(CMP, 0, 1, 2));
      emitBranch(BNE, 13, 1'b1);
      emitBranch(BLT, 14, 1'b0);
      emit(immOp(CMPI, 0, 0, 1));
      emitBranch(BLT, 15, 1'b1);
      emitBranch(BGE, 16, 1'b0);
      emit(immOp(CMPI, 0, 0, 0));
      emitBranch(BE, 17, 1'b1);
      emit(branchOp(BWL, 4));
      emit(immOp(ADDI, 3, 3, 1));  // Runs only after RET
      emitStore(3, 19);
      finalPc = loadPc;
      emit(branchOp(BR, 0));
      emit(byteOp(LLI, 3, 8'h55));
      emitStore(3, 18);
      emit(branchOp(RET, 0));
   endtask

   initial begin
      Clock = 1'b0;
      forever #5 Clock = ~Clock;
   end

   // Memory model on the multiplexed bus, driving only pads the core has released
   assign AddrDataIn = (!Bus.nME && !Bus.nOE && !AddrDataOe) ? mem[memAddr] : 16'h0000;

   always @(posedge Clock) begin
      if (Bus.ALE)
         memAddr <= AddrDataOut[7:0];
      if (!Bus.nME && !Bus.nWE)
         mem[memAddr] <= AddrDataOut;
   end

   // Zero to three wait cycles per data phase, which starts two cycles after ALE
   always @(posedge Clock) begin
      if (Bus.ALE)
         waitLeft = ($urandom % 4) + 1;
      else if (waitLeft > 0)
         waitLeft = waitLeft - 1;
      nWait <= (waitLeft == 0);
   end

   initial begin
      void'($urandom(11276));
      nReset = 1'b0;
      nWait = 1'b1;
      memAddr = '0;
      waitLeft = 0;
      negA = -OpA;
      expected[0] = OpA;
      expected[1] = OpA + OpB;
      expected[2] = OpA - OpB;
      expected[3] = OpA + 16'hFFFF;
      expected[4] = OpA + OpB + 16'h0001;
      expected[5] = OpA & OpB;
      expected[6] = OpA | OpB;
      expected[7] = OpA ^ OpB;
      expected[8] = ~(OpA | OpB);
      expected[9] = OpA << 4;
      expected[10] = {{4{negA[15]}}, negA[15:4]};
      expected[11] = expected[10] >> 4;
      expected[12] = 16'hBEEF;
      expected[18] = 16'h0055;
      expected[19] = 16'h0056;
      loadProgram();
      repeat (5) @(posedge Clock);
      nReset <= 1'b1;
      cycles = 0;
      while (!(Bus.ALE && AddrDataOut == 16'(finalPc))) begin
         @(posedge Clock);
         cycles++;
         if (u_dut.busCheck.Violations != 0)
            stopWithFailure("A bus protocol assertion failed");
         if (cycles > 20000)
            stopWithFailure("The program never reached its end");
      end
      for (int s = 0; s < Slots; s++) begin
         if (mem[ResultBase + s] !== expected[s])
            stopWithFailure($sformatf("[ERROR] %0t ns: result slot %0d is %h, expected %h",
                                      $time, s, mem[ResultBase + s], expected[s]));
      end
      if (u_dut.busCheck.Violations != 0) begin
         stopWithFailure("A bus protocol assertion failed");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule
